// File: mvu_cfg.svh
/*
 * MVU lane configuration
 * Vector size, bank geometry, datapath widths and memory latency
 */
`ifndef MVU_CFG_SVH
`define MVU_CFG_SVH

`define MVU_N               4   // Vector length and number of rows
`define MVU_DBANK_DEPTH     32  // Data bank words
`define MVU_DBANK_AW        5   // Data bank address bits
`define MVU_WBANK_DEPTH     16  // Weight bank words
`define MVU_WBANK_AW        4   // Weight bank address bits

`define MVU_BPREC           2   // Precision field bits, stored as actual minus one
`define MVU_BACC            12  // Accumulator bits
`define MVU_BPOP            3   // Popcount bits, holds 0 to N
`define MVU_BSIG            3   // Shift amount bits, holds up to 6

`define MVU_MEM_RD_LATENCY  1   // Bank read latency in cycles

`endif

// File: mvu_pkg.sv
/*
 * MVU lane package
 * Controller state encoding and datapath word types
 */
`include "mvu_cfg.svh"

package mvu_pkg;

    typedef enum logic [1:0] {
        IDLE,   // Waiting for start
        RUN,    // Issuing plane pairs
        DRAIN,  // Pipeline emptying
        DONE    // One cycle done
    } mvu_state_e;

    typedef logic [`MVU_N-1:0]         dword_t;    // One input bit-plane
    typedef logic [`MVU_N*`MVU_N-1:0]  wword_t;    // One weight bit-plane, row r at r*N
    typedef logic [`MVU_DBANK_AW-1:0]  daddr_t;
    typedef logic [`MVU_WBANK_AW-1:0]  waddr_t;
    typedef logic [`MVU_BPREC-1:0]     prec_t;
    typedef logic [`MVU_BPOP-1:0]      pop_t;
    typedef logic signed [`MVU_BACC-1:0] acc_t;
    typedef logic [`MVU_BSIG-1:0]      sig_t;

    // All row accumulators side by side, row r in element r
    typedef logic [`MVU_N-1:0][`MVU_BACC-1:0] acc_vec_t;

endpackage

// File: mvu_bank.sv
/*
 * MVU memory bank
 * One write port and one read port, read data registered one cycle
 */
`timescale 1ns/1ps

module mvu_bank #(
    parameter int width = 4,
    parameter int depth = 32
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(depth)-1:0] wr_addr,
    input  logic [width-1:0]         wr_word,
    input  logic                     rd_en,
    input  logic [$clog2(depth)-1:0] rd_addr,
    output logic [width-1:0]         rd_word
);

    logic [width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_word;
    end

    // Output holds last read when idle
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_word <= mem[rd_addr];
    end

endmodule

// File: mvu_ctrl.sv
/*
 * MVU job controller
 * Latches the job on start, counts plane pair issues, waits for the
 * pipeline to drain, then pulses done and raises irq
 */
`timescale 1ns/1ps
`include "mvu_cfg.svh"

module mvu_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            i_signed,
    input  logic            w_signed,
    input  mvu_pkg::prec_t  iprec,
    input  mvu_pkg::prec_t  wprec,
    input  mvu_pkg::daddr_t ibaseaddr,
    input  mvu_pkg::waddr_t wbaseaddr,
    input  logic            acc_last,       // Last accumulate has landed
    output logic            busy,
    output logic            done,
    output logic            irq,
    output logic            agu_clr,
    output logic            agu_en,
    output mvu_pkg::prec_t  cfg_iprec,
    output mvu_pkg::prec_t  cfg_wprec,
    output mvu_pkg::daddr_t cfg_ibase,
    output mvu_pkg::waddr_t cfg_wbase,
    output logic            cfg_i_signed,
    output logic            cfg_w_signed
);
    import mvu_pkg::*;

    localparam int BCNT = 2*`MVU_BPREC + 1;  // Holds up to 16 pairs

    mvu_state_e      state;
    logic [BCNT-1:0] issue_cnt;              // Pairs issued so far
    logic [BCNT-1:0] npairs;                 // Pairs in this job
    logic            accept;

    assign npairs  = BCNT'(cfg_iprec + 1) * BCNT'(cfg_wprec + 1);
    assign busy    = (state == RUN) || (state == DRAIN);
    assign accept  = start && !busy;         // Start is dropped mid job
    assign agu_clr = accept;                 // Counters back to MSB planes
    assign agu_en  = (state == RUN);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= IDLE;
            issue_cnt    <= '0;
            done         <= 1'b0;
            irq          <= 1'b0;
            cfg_iprec    <= '0;
            cfg_wprec    <= '0;
            cfg_ibase    <= '0;
            cfg_wbase    <= '0;
            cfg_i_signed <= 1'b0;
            cfg_w_signed <= 1'b0;
        end else begin
            done <= (state == DRAIN) && acc_last;   // Lands together with DONE
            case (state)
                IDLE, DONE: begin
                    if (accept) begin
                        state        <= RUN;
                        issue_cnt    <= '0;
                        irq          <= 1'b0;     // New job clears the interrupt
                        cfg_iprec    <= iprec;
                        cfg_wprec    <= wprec;
                        cfg_ibase    <= ibaseaddr;
                        cfg_wbase    <= wbaseaddr;
                        cfg_i_signed <= i_signed;
                        cfg_w_signed <= w_signed;
                    end else begin
                        state <= IDLE;
                    end
                end
                RUN: begin
                    issue_cnt <= issue_cnt + 1'b1;
                    if (issue_cnt == npairs - 1'b1)
                        state <= DRAIN;           // Last pair goes out this cycle
                end
                DRAIN: begin
                    if (acc_last) begin
                        state <= DONE;
                        irq   <= 1'b1;            // Sticky until next start
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_done_in_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> state == DONE);

    // Job setup must survive a start that arrives mid job
    a_cfg_hold: assert property (@(posedge clk) disable iff (!rst_n)
        start && busy |=> $stable({cfg_iprec, cfg_wprec, cfg_ibase, cfg_wbase,
                                   cfg_i_signed, cfg_w_signed}));

endmodule

// File: mvu_agu.sv
/*
 * MVU bit-plane address generator
 * Walks weight planes (outer) and input planes (inner) from the MSB down
 * and tags each pair with negate, significance and first/last
 */
`timescale 1ns/1ps
`include "mvu_cfg.svh"

module mvu_agu (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            agu_clr,
    input  logic            agu_en,
    input  mvu_pkg::prec_t  cfg_iprec,
    input  mvu_pkg::prec_t  cfg_wprec,
    input  mvu_pkg::daddr_t cfg_ibase,
    input  mvu_pkg::waddr_t cfg_wbase,
    input  logic            cfg_i_signed,
    input  logic            cfg_w_signed,
    output logic            rd_en,
    output mvu_pkg::daddr_t rd_daddr,
    output mvu_pkg::waddr_t rd_waddr,
    output logic            rd_valid,
    output logic            neg,
    output mvu_pkg::sig_t   sig,
    output logic            first,
    output logic            last
);
    import mvu_pkg::*;

    prec_t icnt;    // Input plane index, 0 is MSB
    prec_t wcnt;    // Weight plane index, 0 is MSB
    logic  i_end, w_end;

    assign i_end = (icnt == cfg_iprec);
    assign w_end = (wcnt == cfg_wprec);

    always_ff @(posedge clk) begin
        if (!rst_n || agu_clr) begin
            icnt <= '0;
            wcnt <= '0;
        end else if (agu_en) begin
            icnt <= i_end ? '0 : icnt + 1'b1;
            if (i_end)
                wcnt <= w_end ? '0 : wcnt + 1'b1;  // Next weight plane
        end
    end

    assign rd_en    = agu_en;
    assign rd_valid = agu_en;
    assign rd_daddr = cfg_ibase + daddr_t'(icnt);
    assign rd_waddr = cfg_wbase + waddr_t'(wcnt);
    // Bit weight of plane k is prec minus k for each operand
    assign sig      = sig_t'(cfg_iprec - icnt) + sig_t'(cfg_wprec - wcnt);
    // Signed MSB plane carries negative weight, both MSBs cancel
    assign neg      = agu_en && ((cfg_i_signed && icnt == '0) ^ (cfg_w_signed && wcnt == '0));
    assign first    = agu_en && (icnt == '0) && (wcnt == '0);
    assign last     = agu_en && i_end && w_end;

    // Plane walk must not wrap past the top of either bank
    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> (int'(cfg_ibase) + int'(icnt) < `MVU_DBANK_DEPTH) &&
                  (int'(cfg_wbase) + int'(wcnt) < `MVU_WBANK_DEPTH));

endmodule

// File: mvu_vvp.sv
/*
 * MVU vector-vector product
 * Per row popcount of weight row AND data plane, negated for signed MSB
 * planes and shifted by bit significance, registered once
 */
`timescale 1ns/1ps
`include "mvu_cfg.svh"

module mvu_vvp (
    input  logic              clk,
    input  logic              rst_n,
    input  mvu_pkg::dword_t   dword,
    input  mvu_pkg::wword_t   wword,
    input  logic              rd_valid,
    input  logic              neg,
    input  mvu_pkg::sig_t     sig,
    input  logic              first,
    input  logic              last,
    output mvu_pkg::acc_vec_t prod,
    output logic              prod_valid,
    output logic              prod_first,
    output logic              prod_last
);
    import mvu_pkg::*;

    localparam int LAT  = `MVU_MEM_RD_LATENCY;
    localparam int TAGW = 4 + `MVU_BSIG;

    logic [LAT-1:0][TAGW-1:0] tag_sr;        // Tags waiting for bank data
    logic     tag_valid, tag_first, tag_last, tag_neg;
    sig_t     tag_sig;
    acc_vec_t prod_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_sr <= '0;
        end else begin
            tag_sr[0] <= {rd_valid, first, last, neg, sig};
            for (int i = 1; i < LAT; i++)
                tag_sr[i] <= tag_sr[i-1];
        end
    end

    assign {tag_valid, tag_first, tag_last, tag_neg, tag_sig} = tag_sr[LAT-1];

    always_comb begin
        pop_t pop;
        acc_t term;
        for (int r = 0; r < `MVU_N; r++) begin
            pop = '0;
            for (int c = 0; c < `MVU_N; c++)
                pop = pop + pop_t'(wword[r*`MVU_N + c] & dword[c]);
            term      = acc_t'(pop) <<< tag_sig;     // Zero extend then weight
            prod_d[r] = tag_neg ? -term : term;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= tag_valid;
            prod_first <= tag_valid && tag_first;
            prod_last  <= tag_valid && tag_last;
        end
    end

    always_ff @(posedge clk)
        prod <= prod_d;

endmodule

// File: mvu_shacc.sv
/*
 * MVU shift-accumulators
 * N signed accumulators, loaded on the first product of a job and
 * summed afterwards, held as the result between jobs
 */
`timescale 1ns/1ps
`include "mvu_cfg.svh"

module mvu_shacc (
    input  logic              clk,
    input  logic              rst_n,
    input  mvu_pkg::acc_vec_t prod,
    input  logic              prod_valid,
    input  logic              prod_first,   // Load instead of add
    input  logic              prod_last,
    output mvu_pkg::acc_vec_t result,
    output logic              acc_last      // Last add has landed
);
    import mvu_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result   <= '0;
            acc_last <= 1'b0;
        end else begin
            acc_last <= prod_valid && prod_last;
            if (prod_valid) begin
                for (int r = 0; r < `MVU_N; r++) begin
                    if (prod_first)
                        result[r] <= prod[r];
                    else
                        result[r] <= acc_t'(result[r]) + acc_t'(prod[r]);
                end
            end
        end
    end

    a_first_valid: assert property (@(posedge clk) disable iff (!rst_n)
        prod_first |-> prod_valid);

endmodule

// File: mvu_top.sv
/*
 * MVU lane top level
 * Connects job controller, address generator, data and weight banks,
 * popcount product stage and accumulators
 */
`timescale 1ns/1ps
`include "mvu_cfg.svh"

module mvu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,        // Job start strobe
    input  logic              i_signed,     // Input operand is two's complement
    input  logic              w_signed,     // Weight operand is two's complement
    input  mvu_pkg::prec_t    iprec,        // Input precision minus one
    input  mvu_pkg::prec_t    wprec,        // Weight precision minus one
    input  mvu_pkg::daddr_t   ibaseaddr,    // Input MSB plane address
    input  mvu_pkg::waddr_t   wbaseaddr,    // Weight MSB plane address
    input  logic              wrd_en,       // Data bank write
    input  mvu_pkg::daddr_t   wrd_addr,
    input  mvu_pkg::dword_t   wrd_word,
    input  logic              wrw_en,       // Weight bank write
    input  mvu_pkg::waddr_t   wrw_addr,
    input  mvu_pkg::wword_t   wrw_word,
    output logic              busy,
    output logic              done,
    output logic              irq,
    output mvu_pkg::acc_vec_t result
);
    import mvu_pkg::*;

    logic     agu_clr, agu_en;
    prec_t    cfg_iprec, cfg_wprec;
    daddr_t   cfg_ibase;
    waddr_t   cfg_wbase;
    logic     cfg_i_signed, cfg_w_signed;
    logic     rd_en, rd_valid;
    daddr_t   rd_daddr;
    waddr_t   rd_waddr;
    logic     neg, first, last;
    sig_t     sig;
    dword_t   dword;            // Data bank read word
    wword_t   wword;            // Weight bank read word
    acc_vec_t prod;
    logic     prod_valid, prod_first, prod_last;
    logic     acc_last;

    mvu_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start),
        .i_signed(i_signed), .w_signed(w_signed),
        .iprec(iprec), .wprec(wprec), .ibaseaddr(ibaseaddr), .wbaseaddr(wbaseaddr),
        .acc_last(acc_last),
        .busy(busy), .done(done), .irq(irq), .agu_clr(agu_clr), .agu_en(agu_en),
        .cfg_iprec(cfg_iprec), .cfg_wprec(cfg_wprec),
        .cfg_ibase(cfg_ibase), .cfg_wbase(cfg_wbase),
        .cfg_i_signed(cfg_i_signed), .cfg_w_signed(cfg_w_signed)
    );

    mvu_agu u_agu (
        .clk(clk), .rst_n(rst_n), .agu_clr(agu_clr), .agu_en(agu_en),
        .cfg_iprec(cfg_iprec), .cfg_wprec(cfg_wprec),
        .cfg_ibase(cfg_ibase), .cfg_wbase(cfg_wbase),
        .cfg_i_signed(cfg_i_signed), .cfg_w_signed(cfg_w_signed),
        .rd_en(rd_en), .rd_daddr(rd_daddr), .rd_waddr(rd_waddr), .rd_valid(rd_valid),
        .neg(neg), .sig(sig), .first(first), .last(last)
    );

    mvu_bank #(.width(`MVU_N), .depth(`MVU_DBANK_DEPTH)) data_bank (
        .clk(clk), .wr_en(wrd_en), .wr_addr(wrd_addr), .wr_word(wrd_word),
        .rd_en(rd_en), .rd_addr(rd_daddr), .rd_word(dword)
    );

    mvu_bank #(.width(`MVU_N*`MVU_N), .depth(`MVU_WBANK_DEPTH)) weight_bank (
        .clk(clk), .wr_en(wrw_en), .wr_addr(wrw_addr), .wr_word(wrw_word),
        .rd_en(rd_en), .rd_addr(rd_waddr), .rd_word(wword)
    );

    mvu_vvp u_vvp (
        .clk(clk), .rst_n(rst_n), .dword(dword), .wword(wword),
        .rd_valid(rd_valid), .neg(neg), .sig(sig), .first(first), .last(last),
        .prod(prod), .prod_valid(prod_valid), .prod_first(prod_first), .prod_last(prod_last)
    );

    mvu_shacc u_shacc (
        .clk(clk), .rst_n(rst_n), .prod(prod), .prod_valid(prod_valid),
        .prod_first(prod_first), .prod_last(prod_last),
        .result(result), .acc_last(acc_last)
    );

endmodule

// File: mvu_checker.sv
/*
 * MVU lane checker
 * Watches the lane ports, compares each result with the model value
 * and checks the start, busy, done and irq ordering
 */
`timescale 1ns/1ps
`include "mvu_cfg.svh"

module mvu_checker #(
    parameter int max_cycles = 4096
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              busy,
    input  logic              done,
    input  logic              irq,
    input  mvu_pkg::acc_vec_t result,
    input  mvu_pkg::acc_vec_t exp_result,   // Model value of the running job
    output int                err_count,
    output int                done_count,
    output int                start_count,
    output logic              timed_out
);
    import mvu_pkg::*;

    logic     started;      // A job was accepted since reset
    logic     after_start;  // Accepted start on the previous edge
    logic     pending;      // Job running, done still owed
    logic     holding;      // Result must stay put until next start
    acc_vec_t held;
    int       cycles = 0;

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_result;
        for (int r = 0; r < `MVU_N; r++) begin
            if (result[r] !== exp_result[r]) begin
                $display("error at %0t: result[%0d] = %0d, expected %0d", $time, r,
                         $signed(result[r]), $signed(exp_result[r]));
                err_count++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles == max_cycles) begin
            $display("Timeout: done never came within %0d cycles", max_cycles);
            timed_out = 1'b1;
        end
        if (!rst_n) begin
            {started, after_start, pending, holding, timed_out} = '0;
            err_count   = 0;
            done_count  = 0;
            start_count = 0;
        end else begin
            if (!started) begin                       // Reset values hold until first job
                check_bit("busy", busy, 1'b0);
                check_bit("done", done, 1'b0);
                check_bit("irq", irq, 1'b0);
                if (result !== '0) begin
                    $display("error at %0t: result = %h, expected 0", $time, result);
                    err_count++;
                end
            end
            if (after_start) begin
                check_bit("busy", busy, 1'b1);        // Job is running
                check_bit("irq", irq, 1'b0);          // Cleared by accepted start
                after_start = 1'b0;
            end
            if (done) begin
                if (!pending) begin
                    $display("Done pulsed at %0t with no job running", $time);
                    err_count++;
                end else begin
                    compare_result();
                end
                check_bit("irq", irq, 1'b1);          // Set together with done
                check_bit("busy", busy, 1'b0);        // Dropped together with done
                done_count++;
                pending = 1'b0;
                holding = 1'b1;
                held    = result;
            end else if (holding) begin
                check_bit("irq", irq, 1'b1);          // Sticky until next start
                if (result !== held) begin
                    $display("error at %0t: result = %h, expected held %h", $time, result, held);
                    err_count++;
                end
            end
            if (start && !busy) begin                 // Only idle starts count
                started     = 1'b1;
                after_start = 1'b1;
                pending     = 1'b1;
                holding     = 1'b0;
                start_count++;
            end
        end
    end

endmodule

// File: mvu_tb.sv
/*
 * MVU lane testbench
 * Loads random planes, runs jobs over all precisions and sign modes
 * and predicts each result with a behavioral dot product model
 */
`timescale 1ns/1ps
`include "mvu_cfg.svh"

module mvu_tb;
    import mvu_pkg::*;

    localparam int num_jobs   = 40;
    localparam int job_cycles = 48 + 20;                        // Bank loads plus longest job
    localparam int max_cycles = num_jobs * job_cycles * 3 / 2;  // 50 percent margin

    logic     clk = 1'b0;
    logic     rst_n, start, i_signed, w_signed;
    prec_t    iprec, wprec;
    daddr_t   ibaseaddr, wrd_addr;
    waddr_t   wbaseaddr, wrw_addr;
    logic     wrd_en, wrw_en;
    dword_t   wrd_word;
    wword_t   wrw_word;
    logic     busy, done, irq, timed_out;
    acc_vec_t result, exp_result;
    int       err_count, done_count, start_count;
    integer   seed = 32'hcc4e;
    dword_t   dmem [`MVU_DBANK_DEPTH];    // Model copy of data bank
    wword_t   wmem [`MVU_WBANK_DEPTH];    // Model copy of weight bank

    always #20 clk = ~clk;

    mvu_top UUT (
        .clk(clk), .rst_n(rst_n), .start(start), .i_signed(i_signed), .w_signed(w_signed),
        .iprec(iprec), .wprec(wprec), .ibaseaddr(ibaseaddr), .wbaseaddr(wbaseaddr),
        .wrd_en(wrd_en), .wrd_addr(wrd_addr), .wrd_word(wrd_word),
        .wrw_en(wrw_en), .wrw_addr(wrw_addr), .wrw_word(wrw_word),
        .busy(busy), .done(done), .irq(irq), .result(result)
    );

    mvu_checker #(.max_cycles(max_cycles)) u_checker (
        .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .done(done), .irq(irq),
        .result(result), .exp_result(exp_result), .err_count(err_count),
        .done_count(done_count), .start_count(start_count), .timed_out(timed_out)
    );

    task automatic load_banks;
        logic [31:0] r;
        for (int a = 0; a < `MVU_DBANK_DEPTH; a++) begin
            @(posedge clk);
            r = $random(seed);
            wrd_en   <= 1'b1;
            wrd_addr <= daddr_t'(a);
            wrd_word <= dword_t'(r[3:0]);
            dmem[a]  = dword_t'(r[3:0]);
            wrw_en   <= (a < `MVU_WBANK_DEPTH);   // Weight bank is half as deep
            wrw_addr <= waddr_t'(a);
            wrw_word <= wword_t'(r[31:16]);
            if (a < `MVU_WBANK_DEPTH)
                wmem[a] = wword_t'(r[31:16]);
        end
        @(posedge clk);
        wrd_en <= 1'b0;
        wrw_en <= 1'b0;
    endtask

    // Plain integer dot product, MSB plane weighs minus its place when signed
    task automatic compute_expected(input int ip, input int wp, input int ib, input int wb,
                                    input logic isg, input logic wsg);
        int x [`MVU_N];
        int w [`MVU_N][`MVU_N];
        int bitw, sum;
        for (int c = 0; c < `MVU_N; c++) begin
            x[c] = 0;
            for (int k = 0; k <= ip; k++) begin
                bitw = (isg && k == 0) ? -(1 << (ip - k)) : (1 << (ip - k));
                if (dmem[ib + k][c])
                    x[c] += bitw;
            end
            for (int r = 0; r < `MVU_N; r++) begin
                w[r][c] = 0;
                for (int k = 0; k <= wp; k++) begin
                    bitw = (wsg && k == 0) ? -(1 << (wp - k)) : (1 << (wp - k));
                    if (wmem[wb + k][r*`MVU_N + c])
                        w[r][c] += bitw;
                end
            end
        end
        for (int r = 0; r < `MVU_N; r++) begin
            sum = 0;
            for (int c = 0; c < `MVU_N; c++)
                sum += w[r][c] * x[c];
            exp_result[r] = acc_t'(sum);
        end
    endtask

    task automatic run_job(input int j);
        logic [31:0] r;
        logic [1:0]  mode;
        int          ip, wp, ib, wb;
        r    = $random(seed);
        mode = (j < 16) ? 0 : (j % 3) + 1;          // First 16 jobs sweep unsigned precisions
        ip   = (j < 16) ? j % 4 : r[1:0];
        wp   = (j < 16) ? j / 4 : r[3:2];
        ib   = r[15:8] % (`MVU_DBANK_DEPTH - ip);   // Keep all planes inside the bank
        wb   = r[23:16] % (`MVU_WBANK_DEPTH - wp);
        load_banks();
        compute_expected(ip, wp, ib, wb, mode[0], mode[1]);
        @(posedge clk);
        start     <= 1'b1;
        i_signed  <= mode[0];
        w_signed  <= mode[1];
        iprec     <= prec_t'(ip);
        wprec     <= prec_t'(wp);
        ibaseaddr <= daddr_t'(ib);
        wbaseaddr <= waddr_t'(wb);
        @(posedge clk);
        start <= 1'b0;
        if (j % 4 == 1) begin                       // Stray start mid job, other config
            @(posedge clk);
            start     <= 1'b1;
            iprec     <= prec_t'(ip ^ 3);
            ibaseaddr <= daddr_t'(r[28:24]);
            i_signed  <= ~mode[0];
            @(posedge clk);
            start <= 1'b0;
        end
        do @(posedge clk); while (done !== 1'b1);
    endtask

    task automatic print_summary;
        $display("Jobs %0d, starts accepted %0d, done pulses %0d, errors %0d",
                 num_jobs, start_count, done_count, err_count);
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        i_signed  = 1'b0;
        w_signed  = 1'b0;
        iprec     = '0;
        wprec     = '0;
        ibaseaddr = '0;
        wbaseaddr = '0;
        wrd_en    = 1'b0;
        wrd_addr  = '0;
        wrd_word  = '0;
        wrw_en    = 1'b0;
        wrw_addr  = '0;
        wrw_word  = '0;
        exp_result = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int j = 0; j < num_jobs; j++)
            run_job(j);
        repeat (4) @(posedge clk);
        if (done_count != num_jobs || start_count != num_jobs)
            $display("Job count wrong, expected %0d starts and done pulses", num_jobs);
        print_summary();
        if (err_count == 0 && done_count == num_jobs && start_count == num_jobs) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        @(posedge timed_out);                       // Checker gave up waiting for done
        print_summary();
        $display("Verification failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
mvu_pkg.sv
mvu_bank.sv
mvu_ctrl.sv
mvu_agu.sv
mvu_vvp.sv
mvu_shacc.sv
mvu_top.sv
mvu_checker.sv
mvu_tb.sv

// File: Bender.yml
package:
  name: mvu_lane

export_include_dirs:
  - .

sources:
  - files:
      - mvu_pkg.sv
      - mvu_bank.sv
      - mvu_ctrl.sv
      - mvu_agu.sv
      - mvu_vvp.sv
      - mvu_shacc.sv
      - mvu_top.sv
  - target: simulation
    files:
      - mvu_checker.sv
      - mvu_tb.sv
